// File: Makefile
# Verilator flow for the FPU micro-operation unit

VERILATOR ?= verilator
TOP       ?= fpm_tb
RTL_TOP   ?= fpm_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
SIM_BIN   ?= V$(TOP)
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Finished with no errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(SIM_BIN)

sim: build
	./$(BUILD_DIR)/$(SIM_BIN) 2>&1 | tee $(LOG)
	grep -q -x "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/fpm_ctl.sv
`timescale 1ns/100ps

module fpm_ctl (
	input  logic          f2strob,
	input  logic          _0_d_,
	input  logic          req,
	output logic          ack,
	input  fpm_pkg::fop_t op,
	output logic          load,
	output logic          align_step,
	output logic          align_dec,
	output logic          flush,
	output logic          add_en,
	output logic          fix_step,
	output logic          norm_step,
	output logic          result_en,
	output logic          negate_b,
	output logic          norm_only,
	input  logic          aligned,
	input  logic          far,
	input  logic          sum_ovf,
	input  logic          normed
);

	fpm_pkg::fpm_state_t state;
	fpm_pkg::fpm_state_t state_nxt;
	fpm_pkg::fop_t op_q;
	fpm_pkg::fop_t op_sel;

	// op is taken straight from the port during LOAD, held afterwards
	assign op_sel = (state == fpm_pkg::LOAD) ? op : op_q;
	assign negate_b = (op_sel == fpm_pkg::FOP_SUB);
	assign norm_only = (op_sel == fpm_pkg::FOP_NRF);

	always_comb begin
		state_nxt = state;
		case (state)
			fpm_pkg::IDLE: begin
				if (req)
					state_nxt = fpm_pkg::LOAD;
			end
			fpm_pkg::LOAD: begin
				state_nxt = norm_only ? fpm_pkg::NORM : fpm_pkg::CMP;
			end
			fpm_pkg::CMP: begin
				state_nxt = aligned ? fpm_pkg::ADD : fpm_pkg::ALIGN;
			end
			fpm_pkg::ALIGN: begin
				// far operand goes in a single flush
				if (far || aligned)
					state_nxt = fpm_pkg::ADD;
			end
			fpm_pkg::ADD: begin
				state_nxt = sum_ovf ? fpm_pkg::FIX : fpm_pkg::NORM;
			end
			fpm_pkg::FIX: begin
				state_nxt = fpm_pkg::NORM;
			end
			fpm_pkg::NORM: begin
				if (normed)
					state_nxt = fpm_pkg::DONE;
			end
			fpm_pkg::DONE: begin
				// hold results until the requester lets go
				if (!req)
					state_nxt = fpm_pkg::RELEASE;
			end
			fpm_pkg::RELEASE: begin
				state_nxt = fpm_pkg::IDLE;
			end
			default: begin
				state_nxt = fpm_pkg::IDLE;
			end
		endcase
	end

	// datapath strobes, one cycle each
	assign load = (state == fpm_pkg::LOAD);
	assign align_step = (state == fpm_pkg::ALIGN) && !far;
	assign align_dec = (state == fpm_pkg::ALIGN) && !far;
	assign flush = (state == fpm_pkg::ALIGN) && far;
	assign add_en = (state == fpm_pkg::ADD);
	assign fix_step = (state == fpm_pkg::FIX);
	assign norm_step = (state == fpm_pkg::NORM) && !normed;
	assign result_en = (state == fpm_pkg::NORM) && normed;

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			state <= fpm_pkg::IDLE;
			ack <= 1'b0;
			op_q <= fpm_pkg::FOP_ADD;
		end else begin
			state <= state_nxt;
			// ack high for exactly the DONE stay
			ack <= (state_nxt == fpm_pkg::DONE);
			if (load)
				op_q <= op;
		end
	end

endmodule

// File: design/fpm_exp.sv
`timescale 1ns/100ps

`include "fpm_macros.svh"

module fpm_exp (
	input  logic            f2strob,
	input  logic            _0_d_,
	input  fpm_pkg::exp_t   a_exp,
	input  fpm_pkg::exp_t   b_exp,
	input  logic            load,
	input  logic            align_dec,
	input  logic            fix_step,
	input  logic            norm_step,
	input  logic            norm_only,
	output logic            aligned,
	output logic            far,
	output logic            b_smaller,
	output fpm_pkg::exp_x_t r_exp_x
);

	fpm_pkg::exp_x_t a_x;
	fpm_pkg::exp_x_t b_x;
	fpm_pkg::exp_x_t diff;
	fpm_pkg::exp_x_t dcnt;
	logic diff_neg;

	assign a_x = {{2{a_exp[`FPM_EXP_W-1]}}, a_exp};
	assign b_x = {{2{b_exp[`FPM_EXP_W-1]}}, b_exp};
	assign diff = a_x - b_x;
	assign diff_neg = diff[`FPM_EXP_W+1];

	// shift count that would push every bit out
	assign far = (dcnt >= fpm_pkg::exp_x_t'(`FPM_MANT_W));

	// no step left, or the current step is the last
	assign aligned = (dcnt == '0) || (align_dec && (dcnt == fpm_pkg::exp_x_t'(1)));

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			dcnt <= '0;
			b_smaller <= 1'b0;
		end else if (load) begin
			if (norm_only) begin
				dcnt <= '0;
				b_smaller <= 1'b0;
			end else begin
				dcnt <= diff_neg ? -diff : diff;
				b_smaller <= !diff_neg && (diff != '0);
			end
		end else if (align_dec) begin
			dcnt <= dcnt - fpm_pkg::exp_x_t'(1);
		end
	end

	// result exponent starts from the larger operand
	always_ff @(posedge f2strob) begin
		if (load)
			r_exp_x <= (norm_only || !diff_neg) ? a_x : b_x;
		else if (fix_step)
			r_exp_x <= r_exp_x + fpm_pkg::exp_x_t'(1);
		else if (norm_step)
			r_exp_x <= r_exp_x - fpm_pkg::exp_x_t'(1);
	end

endmodule

// File: design/fpm_flags.sv
`timescale 1ns/100ps

`include "fpm_macros.svh"

module fpm_flags (
	input  logic            f2strob,
	input  logic            _0_d_,
	input  logic            result_en,
	input  fpm_pkg::mant_t  sum,
	input  fpm_pkg::exp_x_t r_exp_x,
	output fpm_pkg::mant_t  r_mant,
	output fpm_pkg::exp_t   r_exp,
	output logic            z_f,
	output logic            m_f,
	output logic            v_f
);

	logic over;
	logic zero;

	// in range only if the two extra bits copy the exponent sign
	assign over = !((&r_exp_x[`FPM_EXP_W+1:`FPM_EXP_W-1]) ||
		!(|r_exp_x[`FPM_EXP_W+1:`FPM_EXP_W-1]));
	assign zero = over || (sum == '0);

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			r_mant <= '0;
			r_exp <= '0;
			z_f <= 1'b0;
			m_f <= 1'b0;
			v_f <= 1'b0;
		end else if (result_en) begin
			r_mant <= zero ? '0 : sum;
			r_exp <= zero ? '0 : r_exp_x[`FPM_EXP_W-1:0];
			z_f <= zero;
			m_f <= !zero && sum[`FPM_MANT_W-1];
			v_f <= over;
		end
	end

endmodule

// File: design/fpm_macros.svh
`ifndef FPM_MACROS_SVH
`define FPM_MACROS_SVH

// mantissa is a two's complement fraction, sign in the top bit
`define FPM_MANT_W 32

// exponent is two's complement
`define FPM_EXP_W 8

`endif

// File: design/fpm_mant.sv
`timescale 1ns/100ps

`include "fpm_macros.svh"

module fpm_mant (
	input  logic           f2strob,
	input  logic           _0_d_,
	input  fpm_pkg::mant_t a_mant,
	input  fpm_pkg::mant_t b_mant,
	input  logic           load,
	input  logic           align_step,
	input  logic           flush,
	input  logic           add_en,
	input  logic           fix_step,
	input  logic           norm_step,
	input  logic           negate_b,
	input  logic           b_smaller,
	input  logic           norm_only,
	output logic           sum_ovf,
	output logic           normed,
	output fpm_pkg::mant_t sum
);

	fpm_pkg::mant_g_t a_g;
	fpm_pkg::mant_g_t b_ext;
	fpm_pkg::mant_g_t b_g;
	fpm_pkg::mant_g_t opa;
	fpm_pkg::mant_g_t opb;
	fpm_pkg::mant_g_t add_res;
	fpm_pkg::mant_g_t sum_r;

	assign a_g = {a_mant[`FPM_MANT_W-1], a_mant};
	assign b_ext = {b_mant[`FPM_MANT_W-1], b_mant};

	// negation in guard width, so -1.0 becomes +1.0 cleanly
	assign b_g = negate_b ? -b_ext : b_ext;

	assign add_res = opa + opb;

	// looked at during ADD, chooses the FIX step
	assign sum_ovf = add_res[`FPM_MANT_W] ^ add_res[`FPM_MANT_W-1];

	assign normed = (sum_r[`FPM_MANT_W-1] ^ sum_r[`FPM_MANT_W-2]) || (sum_r == '0);
	assign sum = sum_r[`FPM_MANT_W-1:0];

	// operand registers, only the smaller one is shifted
	always_ff @(posedge f2strob) begin
		if (load) begin
			opa <= a_g;
			opb <= b_g;
		end else if (align_step) begin
			if (b_smaller)
				opb <= $signed(opb) >>> 1;
			else
				opa <= $signed(opa) >>> 1;
		end else if (flush) begin
			if (b_smaller)
				opb <= {(`FPM_MANT_W+1){opb[`FPM_MANT_W]}};
			else
				opa <= {(`FPM_MANT_W+1){opa[`FPM_MANT_W]}};
		end
	end

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			sum_r <= '0;
		end else if (load) begin
			if (norm_only)
				sum_r <= a_g;
		end else if (add_en) begin
			sum_r <= add_res;
		end else if (fix_step) begin
			// guard bit moves back into the sign
			sum_r <= $signed(sum_r) >>> 1;
		end else if (norm_step) begin
			sum_r <= sum_r << 1;
		end
	end

endmodule

// File: design/fpm_pkg.sv
`include "fpm_macros.svh"

package fpm_pkg;

	// fraction mantissa and its guard-extended form
	typedef logic [`FPM_MANT_W-1:0] mant_t;
	typedef logic [`FPM_MANT_W:0] mant_g_t;

	// exponent, plus two extra bits for the range check
	typedef logic [`FPM_EXP_W-1:0] exp_t;
	typedef logic [`FPM_EXP_W+1:0] exp_x_t;

	typedef enum logic [1:0] {
		FOP_ADD = 2'd0,
		FOP_SUB = 2'd1,
		FOP_NRF = 2'd2
	} fop_t;

	typedef enum logic [3:0] {
		IDLE    = 4'd0,
		LOAD    = 4'd1,
		CMP     = 4'd2,
		ALIGN   = 4'd3,
		ADD     = 4'd4,
		FIX     = 4'd5,
		NORM    = 4'd6,
		DONE    = 4'd7,
		RELEASE = 4'd8
	} fpm_state_t;

endpackage

// File: design/fpm_top.sv
`timescale 1ns/100ps

module fpm_top (
	input  logic           f2strob,
	input  logic           _0_d_,
	input  logic           req,
	output logic           ack,
	input  fpm_pkg::fop_t  op,
	input  fpm_pkg::exp_t  a_exp,
	input  fpm_pkg::mant_t a_mant,
	input  fpm_pkg::exp_t  b_exp,
	input  fpm_pkg::mant_t b_mant,
	output fpm_pkg::exp_t  r_exp,
	output fpm_pkg::mant_t r_mant,
	output logic           z_f,
	output logic           m_f,
	output logic           v_f
);

	logic load;
	logic align_step;
	logic align_dec;
	logic flush;
	logic add_en;
	logic fix_step;
	logic norm_step;
	logic result_en;
	logic negate_b;
	logic norm_only;
	logic aligned;
	logic far;
	logic b_smaller;
	logic sum_ovf;
	logic normed;
	fpm_pkg::mant_t sum;
	fpm_pkg::exp_x_t r_exp_x;

	fpm_ctl u_ctl (
		.f2strob    (f2strob),
		._0_d_      (_0_d_),
		.req        (req),
		.ack        (ack),
		.op         (op),
		.load       (load),
		.align_step (align_step),
		.align_dec  (align_dec),
		.flush      (flush),
		.add_en     (add_en),
		.fix_step   (fix_step),
		.norm_step  (norm_step),
		.result_en  (result_en),
		.negate_b   (negate_b),
		.norm_only  (norm_only),
		.aligned    (aligned),
		.far        (far),
		.sum_ovf    (sum_ovf),
		.normed     (normed)
	);

	fpm_exp u_exp (
		.f2strob   (f2strob),
		._0_d_     (_0_d_),
		.a_exp     (a_exp),
		.b_exp     (b_exp),
		.load      (load),
		.align_dec (align_dec),
		.fix_step  (fix_step),
		.norm_step (norm_step),
		.norm_only (norm_only),
		.aligned   (aligned),
		.far       (far),
		.b_smaller (b_smaller),
		.r_exp_x   (r_exp_x)
	);

	fpm_mant u_mant (
		.f2strob    (f2strob),
		._0_d_      (_0_d_),
		.a_mant     (a_mant),
		.b_mant     (b_mant),
		.load       (load),
		.align_step (align_step),
		.flush      (flush),
		.add_en     (add_en),
		.fix_step   (fix_step),
		.norm_step  (norm_step),
		.negate_b   (negate_b),
		.b_smaller  (b_smaller),
		.norm_only  (norm_only),
		.sum_ovf    (sum_ovf),
		.normed     (normed),
		.sum        (sum)
	);

	fpm_flags u_flags (
		.f2strob   (f2strob),
		._0_d_     (_0_d_),
		.result_en (result_en),
		.sum       (sum),
		.r_exp_x   (r_exp_x),
		.r_mant    (r_mant),
		.r_exp     (r_exp),
		.z_f       (z_f),
		.m_f       (m_f),
		.v_f       (v_f)
	);

endmodule

// File: src.f
+incdir+design
design/fpm_pkg.sv
design/fpm_ctl.sv
design/fpm_exp.sv
design/fpm_mant.sv
design/fpm_flags.sv
design/fpm_top.sv
verif/fpm_tb.sv

// File: verif/fpm_stim.txt
# op a_exp a_mant b_exp b_mant r_exp r_mant z_f m_f v_f, all hex
# op 0 add, 1 subtract, 2 normalize a (b unused)
0 01 20000000 01 10000000 00 60000000 0 0 0
0 03 60000000 03 40000000 04 50000000 0 0 0
0 05 80000000 05 C0000000 06 A0000000 0 1 0
0 02 40000000 00 40000000 02 50000000 0 0 0
0 03 40000000 00 FFFFFFFF 02 7FFFFFFE 0 0 0
0 00 00000003 01 40000000 01 40000001 0 0 0
0 28 40000000 00 7FFFFFFF 28 40000000 0 0 0
0 20 60000000 00 80000000 20 5FFFFFFF 0 0 0
0 00 40000000 E1 80000000 FF 7FFFFFFE 0 0 0
1 01 60000000 01 20000000 01 40000000 0 0 0
1 00 40000001 00 40000000 E2 40000000 0 0 0
1 05 30000000 05 30000000 00 00000000 1 0 0
1 02 20000000 02 60000000 01 80000000 0 1 0
1 03 00000000 03 80000000 04 40000000 0 0 0
1 01 40000000 03 40000000 02 A0000000 0 1 0
2 10 04000000 00 00000000 0C 40000000 0 0 0
2 F0 9ABCDEF0 00 00000000 F0 9ABCDEF0 0 1 0
2 45 00000000 00 00000000 00 00000000 1 0 0
2 00 FFFFFF00 00 00000000 E9 80000000 0 1 0
0 7F 60000000 7F 60000000 00 00000000 1 0 1
2 80 00000001 00 00000000 00 00000000 1 0 1
2 81 20000000 00 00000000 80 40000000 0 0 0

// File: verif/fpm_tb.sv
`timescale 1ns/100ps

module fpm_tb;

	localparam int TIMEOUT = 200;

	logic f2strob;
	logic _0_d_;
	logic req;
	logic ack;
	fpm_pkg::fop_t op;
	fpm_pkg::exp_t a_exp;
	fpm_pkg::mant_t a_mant;
	fpm_pkg::exp_t b_exp;
	fpm_pkg::mant_t b_mant;
	fpm_pkg::exp_t r_exp;
	fpm_pkg::mant_t r_mant;
	logic z_f;
	logic m_f;
	logic v_f;

	int errors;
	int timeouts;
	int n_ops;

	// one stimulus line
	logic [31:0] st_op;
	logic [31:0] st_a_exp;
	logic [31:0] st_a_mant;
	logic [31:0] st_b_exp;
	logic [31:0] st_b_mant;
	logic [31:0] st_r_exp;
	logic [31:0] st_r_mant;
	logic [31:0] st_z;
	logic [31:0] st_m;
	logic [31:0] st_v;

	fpm_top dut (
		.f2strob (f2strob),
		._0_d_   (_0_d_),
		.req     (req),
		.ack     (ack),
		.op      (op),
		.a_exp   (a_exp),
		.a_mant  (a_mant),
		.b_exp   (b_exp),
		.b_mant  (b_mant),
		.r_exp   (r_exp),
		.r_mant  (r_mant),
		.z_f     (z_f),
		.m_f     (m_f),
		.v_f     (v_f)
	);

	always #10 f2strob = ~f2strob;

	task automatic check_val(input string name, input logic [31:0] want,
		input logic [31:0] got);
		assert (got === want) else begin
			$display("[ERROR] t=%0t %s expected %h actual %h", $time, name, want, got);
			errors++;
		end
	endtask

	task automatic check_outputs(
		input logic [31:0] e_exp,
		input logic [31:0] e_mant,
		input logic [31:0] e_z,
		input logic [31:0] e_m,
		input logic [31:0] e_v
	);
		check_val("r_exp", e_exp, 32'(r_exp));
		check_val("r_mant", e_mant, 32'(r_mant));
		check_val("z_f", e_z, 32'(z_f));
		check_val("m_f", e_m, 32'(m_f));
		check_val("v_f", e_v, 32'(v_f));
	endtask

	// ack is sampled on the falling edge where it is stable
	task automatic wait_ack(input logic level, output bit ok);
		int n;
		ok = 1'b0;
		for (n = 0; n < TIMEOUT; n++) begin
			@(negedge f2strob);
			if (ack === level) begin
				ok = 1'b1;
				break;
			end
		end
		if (!ok) begin
			$display("timeout: ack did not go %s within %0d cycles at t=%0t",
				level ? "high" : "low", TIMEOUT, $time);
			timeouts++;
		end
	endtask

	task automatic run_op(output bit ok);
		int gap;
		int hold;
		gap = $urandom % 6;
		hold = $urandom % 6;
		repeat (gap) @(posedge f2strob);
		@(posedge f2strob);
		op <= fpm_pkg::fop_t'(st_op[1:0]);
		a_exp <= fpm_pkg::exp_t'(st_a_exp);
		a_mant <= st_a_mant;
		b_exp <= fpm_pkg::exp_t'(st_b_exp);
		b_mant <= st_b_mant;
		req <= 1'b1;
		wait_ack(1'b1, ok);
		if (!ok)
			return;
		n_ops++;
		check_outputs(st_r_exp, st_r_mant, st_z, st_m, st_v);
		// results must not move while req is held
		repeat (hold) begin
			@(negedge f2strob);
			check_val("ack", 32'd1, 32'(ack));
			check_outputs(st_r_exp, st_r_mant, st_z, st_m, st_v);
		end
		@(posedge f2strob);
		req <= 1'b0;
		// req low is only seen at the next edge
		@(negedge f2strob);
		check_val("ack", 32'd1, 32'(ack));
		wait_ack(1'b0, ok);
		if (!ok)
			return;
		check_outputs(st_r_exp, st_r_mant, st_z, st_m, st_v);
	endtask

	initial begin
		int fd;
		int rc;
		bit ok;
		string line;
		f2strob = 1'b0;
		_0_d_ = 1'b0;
		req = 1'b0;
		op = fpm_pkg::FOP_ADD;
		a_exp = '0;
		a_mant = '0;
		b_exp = '0;
		b_mant = '0;
		errors = 0;
		timeouts = 0;
		n_ops = 0;
		ok = 1'b1;
		void'($urandom(65333));
		repeat (5) @(posedge f2strob);
		_0_d_ <= 1'b1;
		@(negedge f2strob);
		check_val("ack", 32'd0, 32'(ack));
		check_outputs(32'd0, 32'd0, 32'd0, 32'd0, 32'd0);
		fd = $fopen("verif/fpm_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open verif/fpm_stim.txt");
			errors++;
		end else begin
			while (ok && !$feof(fd)) begin
				line = "";
				rc = $fgets(line, fd);
				if (line.len() < 2 || line[0] == "#")
					continue;
				rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", st_op, st_a_exp,
					st_a_mant, st_b_exp, st_b_mant, st_r_exp, st_r_mant, st_z, st_m, st_v);
				if (rc != 10) begin
					$display("stimulus line could not be parsed: %s", line);
					errors++;
					continue;
				end
				run_op(ok);
			end
			$fclose(fd);
		end
		if (n_ops == 0) begin
			$display("no operation was completed");
			errors++;
		end
		$display("operations %0d, errors %0d, timeouts %0d", n_ops, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule
